/* src/pfs_pkg.sv */
package pfs_pkg;

    // Port group geometry
    localparam int PORT_COUNT = 4;
    localparam int TC_COUNT = 4;
    localparam int SRC_COUNT = 2;

    // Per-queue packet counter width, 15 packets max
    localparam int QCNT_W = 4;

    // Derived sizes
    localparam int QUEUES_PER_PORT = TC_COUNT * SRC_COUNT;
    localparam int QUEUE_COUNT = PORT_COUNT * QUEUES_PER_PORT;
    localparam int PAUSE_W = PORT_COUNT * TC_COUNT;
    localparam int PORT_W = $clog2(PORT_COUNT);
    localparam int TC_W = $clog2(TC_COUNT);
    localparam int SRC_W = $clog2(SRC_COUNT);
    // Queue index inside one port, tc above src
    localparam int QIDX_W = TC_W + SRC_W;

    // APB widths
    localparam int APB_AW = 4;
    localparam int APB_DW = 32;

    // Packed value doubles as the flat queue index port*8 + tc*2 + src
    typedef struct packed {
        logic [PORT_W-1:0] port;
        logic [TC_W-1:0]   tc;
        logic [SRC_W-1:0]  src;
    } queue_id_t;

    // Enqueue notification
    typedef struct packed {
        queue_id_t qid;
    } enq_req_t;

    // Fetch request toward the packet read side
    typedef struct packed {
        queue_id_t qid;
    } fetch_req_t;

    // APB word addresses
    typedef enum logic [APB_AW-1:0] {
        REG_CTRL   = 4'h0,
        REG_PAUSE  = 4'h4,
        REG_ISSUED = 4'h8
    } pfs_reg_e;

    // Per-port pending winner slot
    typedef enum logic {
        SCHED_IDLE = 1'b0,
        SCHED_HOLD = 1'b1
    } sched_state_e;

endpackage

/* src/pfs_queue_tracker.sv */
`timescale 1ns/1ps

module pfs_queue_tracker import pfs_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    // Enqueue notifications
    input  logic                   enq_valid,
    input  enq_req_t               enq,
    output logic                   enq_ready,
    // Pops from the scheduler
    input  logic                   pop,
    input  queue_id_t              pop_id,
    // One bit per queue, count nonzero
    output logic [QUEUE_COUNT-1:0] queue_valid
);

    // Packet count per queue
    logic [QUEUE_COUNT-1:0][QCNT_W-1:0] qcnt;
    logic [QUEUE_COUNT-1:0][QCNT_W-1:0] qcnt_nxt;

    // One-hot increment and decrement requests
    logic [QUEUE_COUNT-1:0] inc_vec;
    logic [QUEUE_COUNT-1:0] dec_vec;
    logic                   enq_fire;

    // Back-pressure only when the addressed queue is full
    assign enq_ready = (qcnt[enq.qid] != {QCNT_W{1'b1}});
    assign enq_fire = enq_valid && enq_ready;

    assign inc_vec = enq_fire ? (QUEUE_COUNT'(1) << enq.qid) : '0;
    assign dec_vec = pop ? (QUEUE_COUNT'(1) << pop_id) : '0;

    always_comb begin
        for (int q = 0; q < QUEUE_COUNT; q++) begin
            qcnt_nxt[q] = qcnt[q];
            // Enqueue and pop on the same queue cancel out
            if (inc_vec[q] && !dec_vec[q]) begin
                qcnt_nxt[q] = qcnt[q] + 1'b1;
            end else if (dec_vec[q] && !inc_vec[q] && (qcnt[q] != '0)) begin
                // Never wrap below zero
                qcnt_nxt[q] = qcnt[q] - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            qcnt <= '0;
            queue_valid <= '0;
        end else begin
            qcnt <= qcnt_nxt;
            // Valid flag tracks the new count in the same edge
            for (int q = 0; q < QUEUE_COUNT; q++) begin
                queue_valid[q] <= (qcnt_nxt[q] != '0);
            end
        end
    end

endmodule

/* src/pfs_scheduler.sv */
`timescale 1ns/1ps

module pfs_scheduler import pfs_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    // Configuration
    input  logic                   enable,
    input  logic [PAUSE_W-1:0]     pause_mask,
    input  logic [PAUSE_W-1:0]     pfc,
    // Tracker side
    input  logic [QUEUE_COUNT-1:0] queue_valid,
    output logic                   pop,
    output queue_id_t              pop_id,
    // Issue side
    output logic                   sched_valid,
    output fetch_req_t             sched_req,
    input  logic                   sched_ready
);

    // Port rotation
    logic [PORT_W-1:0] port_q;
    logic [PORT_W-1:0] port_nxt;

    // Pause state, pin flopped once
    logic [PAUSE_W-1:0] pfc_q;
    logic [PAUSE_W-1:0] blocked_tc;
    logic [QUEUE_COUNT-1:0] blocked_q;

    // Arbitration intermediates
    logic [QUEUE_COUNT-1:0]     elig;
    logic [QUEUES_PER_PORT-1:0] cand;
    logic [QIDX_W-1:0]          win_idx;
    logic                       have_win;
    queue_id_t                  win_id;

    // Pending winner per port
    sched_state_e slot_state [PORT_COUNT];
    queue_id_t    slot_qid [PORT_COUNT];
    logic         slot_free;
    logic         capture;
    logic         sched_fire;

    assign port_nxt = port_q + 1'b1;

    always_ff @(posedge clk) begin
        pfc_q <= pfc;
    end

    // Either source blocks a TC
    assign blocked_tc = pfc_q | pause_mask;

    // Spread TC blocking across the sources of each TC
    always_comb begin
        for (int q = 0; q < QUEUE_COUNT; q++) begin
            blocked_q[q] = blocked_tc[q / SRC_COUNT];
        end
    end

    // A popped queue's port comes round again only after the tracker has updated
    assign elig = queue_valid & ~blocked_q & {QUEUE_COUNT{enable}};
    assign cand = elig[port_nxt*QUEUES_PER_PORT +: QUEUES_PER_PORT];

    // Lowest index wins, so lowest TC then lowest source
    always_comb begin
        win_idx = '0;
        for (int i = QUEUES_PER_PORT - 1; i >= 0; i--) begin
            if (cand[i]) begin
                win_idx = QIDX_W'(i);
            end
        end
    end

    assign have_win = |cand;

    always_comb begin
        win_id.port = port_nxt;
        win_id.tc = win_idx[SRC_W +: TC_W];
        win_id.src = win_idx[SRC_W-1:0];
    end

    // Current port slot goes forward
    assign sched_valid = (slot_state[port_q] == SCHED_HOLD);
    assign sched_req.qid = slot_qid[port_q];
    assign sched_fire = sched_valid && sched_ready;

    // Next port's slot must be empty to take a new winner
    assign slot_free = (slot_state[port_nxt] == SCHED_IDLE);
    assign capture = slot_free && have_win;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            port_q <= '0;
            pop <= 1'b0;
            for (int p = 0; p < PORT_COUNT; p++) begin
                slot_state[p] <= SCHED_IDLE;
            end
        end else begin
            port_q <= port_nxt;
            pop <= capture;
            if (sched_fire) begin
                slot_state[port_q] <= SCHED_IDLE;
            end
            if (capture) begin
                slot_state[port_nxt] <= SCHED_HOLD;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            slot_qid[port_nxt] <= win_id;
        end
    end

    // Rotation has moved onto the captured port by the time pop is high
    assign pop_id = slot_qid[port_q];

endmodule

/* src/pfs_fetch_issue.sv */
`timescale 1ns/1ps

module pfs_fetch_issue import pfs_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    // From scheduler
    input  logic       sched_valid,
    input  fetch_req_t sched_req,
    output logic       sched_ready,
    // Toward packet read side
    output logic       fetch_valid,
    output fetch_req_t fetch,
    input  logic       fetch_ready,
    // Completed transfer strobe for the counter
    output logic       issued
);

    logic fetch_fire;
    logic load;

    assign fetch_fire = fetch_valid && fetch_ready;

    // Accept when empty or emptying this cycle
    assign sched_ready = !fetch_valid || fetch_ready;
    assign load = sched_valid && sched_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_valid <= 1'b0;
        end else if (sched_ready) begin
            // Refill or go empty
            fetch_valid <= sched_valid;
        end
    end

    // Payload held while stalled
    always_ff @(posedge clk) begin
        if (load) begin
            fetch <= sched_req;
        end
    end

    // One strobe per outside handshake
    assign issued = fetch_fire;

endmodule

/* src/pfs_apb_regs.sv */
`timescale 1ns/1ps

module pfs_apb_regs import pfs_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    // APB slave
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [APB_AW-1:0] paddr,
    input  logic [APB_DW-1:0] pwdata,
    output logic [APB_DW-1:0] prdata,
    output logic              pready,
    // Status and control
    input  logic              issued,
    output logic              enable,
    output logic [PAUSE_W-1:0] pause_mask
);

    logic [APB_DW-1:0] issue_cnt;
    logic [APB_DW-1:0] rd_data;
    logic              apb_wr;
    logic              apb_rd_setup;

    // No wait states
    assign pready = 1'b1;

    // Writes land in the access phase
    assign apb_wr = psel && penable && pwrite;
    // Read data captured at setup so it is stable through access
    assign apb_rd_setup = psel && !penable && !pwrite;

    always_comb begin
        case (paddr)
            REG_CTRL:   rd_data = {{(APB_DW-1){1'b0}}, enable};
            REG_PAUSE:  rd_data = {{(APB_DW-PAUSE_W){1'b0}}, pause_mask};
            REG_ISSUED: rd_data = issue_cnt;
            default:    rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable <= 1'b0;
            pause_mask <= '0;
        end else if (apb_wr) begin
            case (paddr)
                REG_CTRL:  enable <= pwdata[0];
                REG_PAUSE: pause_mask <= pwdata[PAUSE_W-1:0];
                // Issue count is read only
                default: ;
            endcase
        end
    end

    // Free-running count of completed fetches
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue_cnt <= '0;
        end else if (issued) begin
            issue_cnt <= issue_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prdata <= '0;
        end else if (apb_rd_setup) begin
            prdata <= rd_data;
        end
    end

endmodule

/* src/pfs_top.sv */
`timescale 1ns/1ps

module pfs_top import pfs_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    // Enqueue notifications
    input  logic              enq_valid,
    output logic              enq_ready,
    input  enq_req_t          enq,
    // PFC pause per port and TC
    input  logic [PAUSE_W-1:0] pfc,
    // Fetch requests out
    output logic              fetch_valid,
    input  logic              fetch_ready,
    output fetch_req_t        fetch,
    // APB configuration
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [APB_AW-1:0] paddr,
    input  logic [APB_DW-1:0] pwdata,
    output logic [APB_DW-1:0] prdata,
    output logic              pready
);

    // Tracker and scheduler
    logic [QUEUE_COUNT-1:0] queue_valid;
    logic                   pop;
    queue_id_t              pop_id;

    // Scheduler and issue
    logic       sched_valid;
    logic       sched_ready;
    fetch_req_t sched_req;

    // Register block links
    logic               issued;
    logic               enable;
    logic [PAUSE_W-1:0] pause_mask;

    pfs_queue_tracker pfs_queue_tracker_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .enq_valid   (enq_valid),
        .enq         (enq),
        .enq_ready   (enq_ready),
        .pop         (pop),
        .pop_id      (pop_id),
        .queue_valid (queue_valid)
    );

    pfs_scheduler pfs_scheduler_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (enable),
        .pause_mask  (pause_mask),
        .pfc         (pfc),
        .queue_valid (queue_valid),
        .pop         (pop),
        .pop_id      (pop_id),
        .sched_valid (sched_valid),
        .sched_req   (sched_req),
        .sched_ready (sched_ready)
    );

    pfs_fetch_issue pfs_fetch_issue_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .sched_valid (sched_valid),
        .sched_req   (sched_req),
        .sched_ready (sched_ready),
        .fetch_valid (fetch_valid),
        .fetch       (fetch),
        .fetch_ready (fetch_ready),
        .issued      (issued)
    );

    pfs_apb_regs pfs_apb_regs_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .issued     (issued),
        .enable     (enable),
        .pause_mask (pause_mask)
    );

endmodule

/* sim/pfs_tb.sv */
`timescale 1ns/1ps

module pfs_tb import pfs_pkg::*; ();

    logic              clk;
    logic              rst_n;
    logic              enq_valid;
    logic              enq_ready;
    enq_req_t          enq;
    logic [PAUSE_W-1:0] pfc;
    logic              fetch_valid;
    logic              fetch_ready;
    fetch_req_t        fetch;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata;
    logic [APB_DW-1:0] prdata;
    logic              pready;

    // Scoreboard, per queue and in arrival order
    int        enq_cnt [QUEUE_COUNT];
    int        fetch_cnt [QUEUE_COUNT];
    queue_id_t fetch_log [$];
    int        enq_total;
    int        errors;
    int        tests_run;
    logic [15:0] lfsr;
    // Last stalled fetch, must not change until taken
    logic       stall_seen;
    fetch_req_t stall_val;

    pfs_top pfs_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .enq_valid   (enq_valid),
        .enq_ready   (enq_ready),
        .enq         (enq),
        .pfc         (pfc),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch       (fetch),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_error(input string msg);
        $display("ERROR: %s", msg);
        errors++;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
        errors++;
    endtask

    // Galois LFSR, taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic queue_id_t random_qid();
        logic [$bits(queue_id_t)-1:0] v;
        for (int b = 0; b < $bits(queue_id_t); b++) begin
            v[b] = lfsr_bit();
        end
        return queue_id_t'(v);
    endfunction

    function automatic queue_id_t make_qid(input int p, input int t, input int s);
        queue_id_t q;
        q.port = PORT_W'(p);
        q.tc = TC_W'(t);
        q.src = SRC_W'(s);
        return q;
    endfunction

    // Handshake monitor, both sides sampled on the rising edge
    always @(posedge clk) begin
        if (!rst_n) begin
            stall_seen = 1'b0;
        end else begin
            if (enq_valid && enq_ready) begin
                enq_cnt[int'(enq.qid)]++;
                enq_total++;
            end
            if (stall_seen && !fetch_valid) begin
                report_error("fetch_valid dropped while the fetch was stalled");
            end
            if (stall_seen && fetch_valid && (fetch != stall_val)) begin
                report_mismatch("fetch", 32'(fetch), 32'(stall_val));
            end
            if (fetch_valid && fetch_ready) begin
                fetch_log.push_back(fetch.qid);
                fetch_cnt[int'(fetch.qid)]++;
            end
            stall_seen = fetch_valid && !fetch_ready;
            stall_val = fetch;
        end
    end

    task automatic apb_access(input logic wr, input logic [APB_AW-1:0] addr,
                              input logic [APB_DW-1:0] wdata, output logic [APB_DW-1:0] rdata);
        int n;
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= wr;
        paddr <= addr;
        pwdata <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!pready && n < 16);
        if (!pready) begin
            report_error("APB access never saw pready");
        end
        rdata = prdata;
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
    endtask

    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
        logic [APB_DW-1:0] unused_rd;
        apb_access(1'b1, addr, data, unused_rd);
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data);
        apb_access(1'b0, addr, '0, data);
    endtask

    task automatic send_enq(input queue_id_t qid);
        int n;
        @(posedge clk);
        enq_valid <= 1'b1;
        enq.qid <= qid;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!enq_ready && n < 200);
        if (!enq_ready) begin
            report_error("enqueue was never accepted");
        end
        enq_valid <= 1'b0;
    endtask

    task automatic wait_fetches(input int total, input int limit);
        int n;
        n = 0;
        while (fetch_log.size() < total && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (fetch_log.size() < total) begin
            report_error($sformatf("timed out waiting for %0d fetches, saw %0d",
                                   total, fetch_log.size()));
        end
    endtask

    task automatic check_drained();
        for (int q = 0; q < QUEUE_COUNT; q++) begin
            if (fetch_cnt[q] != enq_cnt[q]) begin
                report_mismatch($sformatf("fetch_cnt[%0d]", q), 32'(fetch_cnt[q]),
                                32'(enq_cnt[q]));
            end
        end
    endtask

    task automatic finish_test(input string name, input int err0);
        tests_run++;
        $display("test %0d %s: %s", tests_run, name, (errors == err0) ? "ok" : "errors");
    endtask

    task automatic test_reset();
        int err0;
        int base;
        logic [APB_DW-1:0] rd;
        err0 = errors;
        @(negedge clk);
        if (fetch_valid !== 1'b0) begin
            report_mismatch("fetch_valid", 32'(fetch_valid), 32'h0);
        end
        if (enq_ready !== 1'b1) begin
            report_mismatch("enq_ready", 32'(enq_ready), 32'h1);
        end
        apb_read(REG_CTRL, rd);
        if (rd !== '0) begin
            report_mismatch("REG_CTRL", rd, 32'h0);
        end
        apb_read(REG_PAUSE, rd);
        if (rd !== '0) begin
            report_mismatch("REG_PAUSE", rd, 32'h0);
        end
        apb_read(REG_ISSUED, rd);
        if (rd !== '0) begin
            report_mismatch("REG_ISSUED", rd, 32'h0);
        end
        // Scheduler still disabled, packet must stay queued
        base = fetch_log.size();
        send_enq(make_qid(0, 1, 0));
        repeat (PORT_COUNT + 3) @(negedge clk);
        if (fetch_log.size() != base) begin
            report_error("fetch issued while the scheduler is disabled");
        end
        finish_test("reset values and disable", err0);
    endtask

    task automatic test_single();
        int err0;
        int base;
        queue_id_t qid;
        err0 = errors;
        base = fetch_log.size();
        qid = make_qid(3, 2, 1);
        apb_write(REG_CTRL, 32'h1);
        // Packet held back by the previous test comes out first
        wait_fetches(base + 1, 20);
        if (fetch_log.size() > base && fetch_log[base] != make_qid(0, 1, 0)) begin
            report_mismatch("fetch", 32'(fetch_log[base]), 32'(make_qid(0, 1, 0)));
        end
        base = base + 1;
        send_enq(qid);
        wait_fetches(base + 1, PORT_COUNT + 3);
        repeat (16) @(negedge clk);
        if (fetch_log.size() != base + 1) begin
            report_mismatch("fetch count", 32'(fetch_log.size() - base), 32'h1);
        end else if (fetch_log[base] != qid) begin
            report_mismatch("fetch", 32'(fetch_log[base]), 32'(qid));
        end
        check_drained();
        finish_test("single enqueue", err0);
    endtask

    task automatic test_priority();
        int err0;
        int base;
        int load [QUEUES_PER_PORT];
        queue_id_t exp_seq [$];
        err0 = errors;
        // Packets per queue of port 2, index tc * SRC_COUNT + src
        load = '{1, 2, 1, 1, 0, 0, 0, 2};
        apb_write(REG_CTRL, 32'h0);
        @(posedge clk);
        fetch_ready <= 1'b0;
        for (int i = QUEUES_PER_PORT - 1; i >= 0; i--) begin
            for (int k = 0; k < load[i]; k++) begin
                send_enq(make_qid(2, i / SRC_COUNT, i % SRC_COUNT));
            end
        end
        // Strict priority, lowest TC first then lowest source
        for (int t = 0; t < TC_COUNT; t++) begin
            for (int s = 0; s < SRC_COUNT; s++) begin
                for (int k = 0; k < load[t * SRC_COUNT + s]; k++) begin
                    exp_seq.push_back(make_qid(2, t, s));
                end
            end
        end
        base = fetch_log.size();
        apb_write(REG_CTRL, 32'h1);
        repeat (12) @(negedge clk);
        @(posedge clk);
        fetch_ready <= 1'b1;
        wait_fetches(base + exp_seq.size(), 100);
        for (int i = 0; i < exp_seq.size(); i++) begin
            if (base + i < fetch_log.size() && fetch_log[base + i] != exp_seq[i]) begin
                report_mismatch($sformatf("fetch #%0d", i), 32'(fetch_log[base + i]),
                                32'(exp_seq[i]));
            end
        end
        check_drained();
        finish_test("strict priority", err0);
    endtask

    // Pauses port 1 TC 2, by register or by the pfc pin
    task automatic pause_run(input logic use_pin);
        int base;
        int bit_idx;
        base = fetch_log.size();
        bit_idx = 1 * TC_COUNT + 2;
        if (use_pin) begin
            @(posedge clk);
            pfc <= PAUSE_W'(1) << bit_idx;
        end else begin
            apb_write(REG_PAUSE, 32'(1) << bit_idx);
        end
        repeat (2) @(negedge clk);
        send_enq(make_qid(1, 2, 0));
        send_enq(make_qid(1, 2, 1));
        send_enq(make_qid(1, 0, 1));
        wait_fetches(base + 1, 40);
        repeat (24) @(negedge clk);
        for (int i = base; i < fetch_log.size(); i++) begin
            if (fetch_log[i].port == 1 && fetch_log[i].tc == 2) begin
                report_error("fetch from a paused traffic class");
            end
        end
        if (fetch_log.size() != base + 1) begin
            report_mismatch("fetch count while paused", 32'(fetch_log.size() - base), 32'h1);
        end
        if (use_pin) begin
            @(posedge clk);
            pfc <= '0;
        end else begin
            apb_write(REG_PAUSE, 32'h0);
        end
        wait_fetches(base + 3, 40);
        check_drained();
    endtask

    task automatic test_pause();
        int err0;
        err0 = errors;
        pause_run(1'b0);
        pause_run(1'b1);
        finish_test("pause by register and pin", err0);
    endtask

    task automatic test_random();
        int err0;
        int sent;
        int n;
        err0 = errors;
        sent = 0;
        n = 0;
        while (sent < 120 && n < 4000) begin
            @(posedge clk);
            n++;
            if (enq_valid && enq_ready) begin
                sent++;
            end
            fetch_ready <= lfsr_bit();
            if (sent < 120 && (!enq_valid || enq_ready)) begin
                enq_valid <= 1'b1;
                enq.qid <= random_qid();
            end else if (sent >= 120) begin
                enq_valid <= 1'b0;
            end
        end
        if (sent < 120) begin
            report_error("random enqueues did not complete in time");
        end
        @(posedge clk);
        enq_valid <= 1'b0;
        fetch_ready <= 1'b1;
        @(negedge clk);
        wait_fetches(enq_total, 1000);
        repeat (20) @(negedge clk);
        if (fetch_log.size() != enq_total) begin
            report_mismatch("total fetches", 32'(fetch_log.size()), 32'(enq_total));
        end
        check_drained();
        finish_test("random back-pressure", err0);
    endtask

    task automatic test_counters();
        int err0;
        int q;
        logic [APB_DW-1:0] rd;
        queue_id_t qid;
        err0 = errors;
        qid = make_qid(3, 3, 1);
        q = int'(qid);
        apb_read(REG_ISSUED, rd);
        if (rd != 32'(fetch_log.size())) begin
            report_mismatch("REG_ISSUED", rd, 32'(fetch_log.size()));
        end
        // Fill one queue to its limit with the scheduler stopped
        apb_write(REG_CTRL, 32'h0);
        for (int k = 0; k < 15; k++) begin
            send_enq(qid);
        end
        @(posedge clk);
        enq_valid <= 1'b1;
        enq.qid <= qid;
        for (int k = 0; k < 8; k++) begin
            @(negedge clk);
            if (enq_ready !== 1'b0) begin
                report_mismatch("enq_ready", 32'(enq_ready), 32'h0);
            end
        end
        @(posedge clk);
        enq_valid <= 1'b0;
        if (enq_cnt[q] - fetch_cnt[q] != 15) begin
            report_mismatch("accepted into full queue", 32'(enq_cnt[q] - fetch_cnt[q]), 32'd15);
        end
        apb_write(REG_CTRL, 32'h1);
        @(negedge clk);
        wait_fetches(enq_total, 200);
        check_drained();
        apb_read(REG_ISSUED, rd);
        if (rd != 32'(fetch_log.size())) begin
            report_mismatch("REG_ISSUED", rd, 32'(fetch_log.size()));
        end
        finish_test("issue count and full queue", err0);
    endtask

    initial begin
        rst_n = 1'b0;
        enq_valid = 1'b0;
        enq = '0;
        pfc = '0;
        fetch_ready = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        lfsr = 16'd65;
        errors = 0;
        tests_run = 0;
        enq_total = 0;
        stall_seen = 1'b0;
        stall_val = '0;
        for (int q = 0; q < QUEUE_COUNT; q++) begin
            enq_cnt[q] = 0;
            fetch_cnt[q] = 0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_single();
        test_priority();
        test_pause();
        test_random();
        test_counters();
        $display("tests %0d, errors %0d, enqueues %0d, fetches %0d",
                 tests_run, errors, enq_total, fetch_log.size());
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* compile.f */
src/pfs_pkg.sv
src/pfs_queue_tracker.sv
src/pfs_scheduler.sv
src/pfs_fetch_issue.sv
src/pfs_apb_regs.sv
src/pfs_top.sv
sim/pfs_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= pfs_tb
FILELIST ?= compile.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_STR ?= PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_STR)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
